//--- common/gb_cpu_pkg.sv
package gb_cpu_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] addr_t;

  // Register code as found in opcode bit fields: B C D E H L (HL) A.
  typedef logic [2:0] reg_sel_t;

  // Register pair code: 0 BC, 1 DE, 2 HL.
  typedef logic [1:0] pair_sel_t;

  typedef logic [1:0] mcycle_t;
  typedef logic [1:0] tstate_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_LD_R_R,
    OP_LD_R_IMM,
    OP_LD_R_HL,
    OP_LD_HL_R,
    OP_LD_RR_IMM,
    OP_ALU,
    OP_COMPARE
  } op_class_e;

  // The first eight follow opcode bits 5:3 of the 0x80-0xBF block.
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_SBC,
    ALU_AND,
    ALU_XOR,
    ALU_OR,
    ALU_CP,
    ALU_INC,
    ALU_DEC,
    ALU_NONE
  } alu_op_e;

  localparam addr_t RESET_PC = 16'h0100;  // Cartridge entry point.

  localparam int T_STATES_PER_M = 4;

  localparam reg_sel_t REG_H = 3'd4;
  localparam reg_sel_t REG_L = 3'd5;
  localparam reg_sel_t REG_HL_MEM = 3'd6;  // Memory operand at address HL.
  localparam reg_sel_t REG_A = 3'd7;

endpackage

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import gb_cpu_pkg::*; (
  input  byte_t     i_ir,
  output op_class_e o_op_class,
  output reg_sel_t  o_dst_sel,
  output reg_sel_t  o_src_sel,
  output pair_sel_t o_pair_sel,
  output alu_op_e   o_alu_op,
  output mcycle_t   o_m_cycles
);

  reg_sel_t field_hi;
  reg_sel_t field_lo;

  assign field_hi = i_ir[5:3];
  assign field_lo = i_ir[2:0];

  always_comb begin
    o_op_class = OP_NOP;
    o_dst_sel  = field_hi;
    o_src_sel  = field_lo;
    o_pair_sel = i_ir[5:4];
    o_alu_op   = ALU_NONE;

    case (i_ir[7:6])
      2'b00: begin
        case (field_lo)
          3'b100, 3'b101: begin
            if (field_hi != REG_HL_MEM) begin
              o_op_class = OP_ALU;
              o_src_sel  = field_hi;  // Operand comes through the normal read port.
              o_alu_op   = i_ir[0] ? ALU_DEC : ALU_INC;
            end
          end
          3'b110: begin
            if (field_hi != REG_HL_MEM) begin
              o_op_class = OP_LD_R_IMM;
            end
          end
          3'b001: begin
            if (!i_ir[3] && i_ir[5:4] != 2'b11) begin  // Pair code 3 is SP.
              o_op_class = OP_LD_RR_IMM;
            end
          end
          default: ;
        endcase
      end

      2'b01: begin
        if (field_hi == REG_HL_MEM && field_lo == REG_HL_MEM) begin
          o_op_class = OP_NOP;  // HALT.
        end else if (field_hi == REG_HL_MEM) begin
          o_op_class = OP_LD_HL_R;
        end else if (field_lo == REG_HL_MEM) begin
          o_op_class = OP_LD_R_HL;
        end else begin
          o_op_class = OP_LD_R_R;
        end
      end

      2'b10: begin
        if (field_lo != REG_HL_MEM) begin
          o_dst_sel  = REG_A;
          o_alu_op   = alu_op_e'({1'b0, field_hi});
          o_op_class = (field_hi == 3'd7) ? OP_COMPARE : OP_ALU;
        end
      end

      default: ;
    endcase
  end

  // Index of the final machine cycle, one less than the instruction length.
  always_comb begin
    case (o_op_class)
      OP_LD_R_IMM, OP_LD_R_HL: o_m_cycles = 2'd2;
      OP_LD_RR_IMM:            o_m_cycles = 2'd3;
      default:                 o_m_cycles = 2'd1;
    endcase
  end

endmodule

//--- decode/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer import gb_cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  byte_t     i_mem_rd_data,
  input  op_class_e i_op_class,
  input  mcycle_t   i_m_cycles,
  input  addr_t     i_hl,
  output addr_t     o_mem_rd_addr,
  output byte_t     o_ir,
  output addr_t     o_operand,
  output logic      o_commit
);

  localparam tstate_t T_LAST = tstate_t'(T_STATES_PER_M - 1);

  addr_t   pc;
  tstate_t tstate;
  mcycle_t mcycle;
  byte_t   ir_q;
  addr_t   operand_q;

  logic    cycle_end;
  logic    fetch_cycle;
  logic    last_cycle;
  logic    operand_cycle;
  logic    pc_step;
  addr_t   pc_next;
  mcycle_t mcycle_next;
  addr_t   rd_addr_next;

  assign cycle_end     = (tstate == T_LAST);
  assign fetch_cycle   = (mcycle == 2'd0);
  assign last_cycle    = (mcycle == i_m_cycles);
  assign operand_cycle = !fetch_cycle && !last_cycle;

  // Immediate bytes advance PC; the HL data cycle does not.
  assign pc_step     = fetch_cycle || (operand_cycle && i_op_class != OP_LD_R_HL);
  assign pc_next     = pc_step ? pc + 16'd1 : pc;
  assign mcycle_next = last_cycle ? 2'd0 : mcycle + 2'd1;

  always_comb begin
    rd_addr_next = pc_next;
    if (i_op_class == OP_LD_R_HL && mcycle_next == 2'd1) begin
      rd_addr_next = i_hl;
    end
  end

  // At the end of the fetch the new opcode is decoded straight from the bus,
  // so the first operand cycle already reads from the right address.
  assign o_ir = (fetch_cycle && cycle_end) ? i_mem_rd_data : ir_q;

  assign o_commit  = last_cycle && cycle_end;
  assign o_operand = operand_q;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      pc            <= RESET_PC;
      tstate        <= '0;
      mcycle        <= '0;
      ir_q          <= 8'h00;
      o_mem_rd_addr <= RESET_PC;
    end else begin
      tstate <= cycle_end ? '0 : tstate + 2'd1;
      if (cycle_end) begin
        mcycle        <= mcycle_next;
        pc            <= pc_next;
        o_mem_rd_addr <= rd_addr_next;
        if (fetch_cycle) begin
          ir_q <= i_mem_rd_data;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (cycle_end && operand_cycle) begin
      if (mcycle == 2'd1) begin
        operand_q[7:0] <= i_mem_rd_data;  // First byte is the low byte.
      end else begin
        operand_q[15:8] <= i_mem_rd_data;
      end
    end
  end

endmodule

//--- execute/reg_file.sv
`timescale 1ns/1ps

module reg_file import gb_cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_sel_t  i_rd_sel,
  input  logic      i_wr_en,
  input  reg_sel_t  i_wr_sel,
  input  byte_t     i_wr_data,
  input  logic      i_pair_wr_en,
  input  pair_sel_t i_pair_sel,
  input  addr_t     i_pair_wr_data,
  output byte_t     o_rd_data,
  output byte_t     o_acc,
  output addr_t     o_hl
);

  byte_t regs [0:7];  // Indexed by register code; slot 6 is never written.

  reg_sel_t pair_hi;
  reg_sel_t pair_lo;

  assign pair_hi = {i_pair_sel, 1'b0};
  assign pair_lo = {i_pair_sel, 1'b1};

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (i_pair_wr_en) begin
      regs[pair_hi] <= i_pair_wr_data[15:8];
      regs[pair_lo] <= i_pair_wr_data[7:0];
    end else if (i_wr_en && i_wr_sel != REG_HL_MEM) begin
      regs[i_wr_sel] <= i_wr_data;
    end
  end

  assign o_rd_data = regs[i_rd_sel];
  assign o_acc     = regs[REG_A];
  assign o_hl      = {regs[REG_H], regs[REG_L]};

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps

module alu import gb_cpu_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  alu_op_e i_op,
  input  byte_t   i_acc,
  input  byte_t   i_src,
  input  logic    i_commit,
  output byte_t   o_result
);

  logic       carry_q;
  logic [8:0] wide;  // Bit 8 is the carry out or the borrow.

  always_comb begin
    case (i_op)
      ALU_ADD: wide = {1'b0, i_acc} + {1'b0, i_src};
      ALU_ADC: wide = {1'b0, i_acc} + {1'b0, i_src} + {8'd0, carry_q};
      ALU_SUB,
      ALU_CP:  wide = {1'b0, i_acc} - {1'b0, i_src};
      ALU_SBC: wide = {1'b0, i_acc} - {1'b0, i_src} - {8'd0, carry_q};
      ALU_AND: wide = {1'b0, i_acc & i_src};
      ALU_XOR: wide = {1'b0, i_acc ^ i_src};
      ALU_OR:  wide = {1'b0, i_acc | i_src};
      ALU_INC: wide = {1'b0, i_src + 8'd1};
      ALU_DEC: wide = {1'b0, i_src - 8'd1};
      default: wide = {1'b0, i_src};
    endcase
  end

  assign o_result = wide[7:0];

  // Logic ops leave bit 8 clear, which clears the carry.
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      carry_q <= 1'b0;
    end else if (i_commit && i_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
                                          ALU_AND, ALU_XOR, ALU_OR, ALU_CP}) begin
      carry_q <= wide[8];
    end
  end

endmodule

//--- result/writeback_ctrl.sv
`timescale 1ns/1ps

module writeback_ctrl import gb_cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_commit,
  input  op_class_e i_op_class,
  input  reg_sel_t  i_dst_sel,
  input  byte_t     i_src_data,
  input  byte_t     i_alu_result,
  input  addr_t     i_operand,
  input  addr_t     i_hl,
  output logic      o_reg_wr_en,
  output reg_sel_t  o_reg_wr_sel,
  output byte_t     o_reg_wr_data,
  output logic      o_pair_wr_en,
  output addr_t     o_pair_wr_data,
  output logic      o_mem_wr_en,
  output addr_t     o_mem_wr_addr,
  output byte_t     o_mem_wr_data
);

  logic store;

  assign o_reg_wr_en = i_commit &&
                       (i_op_class inside {OP_LD_R_R, OP_LD_R_IMM, OP_LD_R_HL, OP_ALU});
  assign o_reg_wr_sel = i_dst_sel;

  always_comb begin
    case (i_op_class)
      OP_LD_R_R:               o_reg_wr_data = i_src_data;
      OP_LD_R_IMM, OP_LD_R_HL: o_reg_wr_data = i_operand[7:0];
      default:                 o_reg_wr_data = i_alu_result;
    endcase
  end

  assign o_pair_wr_en   = i_commit && (i_op_class == OP_LD_RR_IMM);
  assign o_pair_wr_data = i_operand;

  assign store = i_commit && (i_op_class == OP_LD_HL_R);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_mem_wr_en <= 1'b0;
    end else begin
      o_mem_wr_en <= store;  // High for the one clock after the commit.
    end
  end

  always_ff @(posedge i_clk) begin
    if (store) begin
      o_mem_wr_addr <= i_hl;
      o_mem_wr_data <= i_src_data;
    end
  end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import gb_cpu_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  byte_t i_mem_rd_data,
  output addr_t o_mem_rd_addr,
  output logic  o_mem_wr_en,
  output addr_t o_mem_wr_addr,
  output byte_t o_mem_wr_data
);

  byte_t     ir;
  op_class_e op_class;
  reg_sel_t  dst_sel;
  reg_sel_t  src_sel;
  pair_sel_t pair_sel;
  alu_op_e   alu_op;
  mcycle_t   m_cycles;
  addr_t     operand;
  logic      commit;
  byte_t     rd_data;
  byte_t     acc;
  addr_t     hl;
  byte_t     alu_result;
  logic      reg_wr_en;
  reg_sel_t  reg_wr_sel;
  byte_t     reg_wr_data;
  logic      pair_wr_en;
  addr_t     pair_wr_data;

  instr_decoder u_decoder (
    .i_ir       (ir),
    .o_op_class (op_class),
    .o_dst_sel  (dst_sel),
    .o_src_sel  (src_sel),
    .o_pair_sel (pair_sel),
    .o_alu_op   (alu_op),
    .o_m_cycles (m_cycles)
  );

  cycle_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .i_op_class    (op_class),
    .i_m_cycles    (m_cycles),
    .i_hl          (hl),
    .o_mem_rd_addr (o_mem_rd_addr),
    .o_ir          (ir),
    .o_operand     (operand),
    .o_commit      (commit)
  );

  reg_file u_reg_file (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_rd_sel       (src_sel),
    .i_wr_en        (reg_wr_en),
    .i_wr_sel       (reg_wr_sel),
    .i_wr_data      (reg_wr_data),
    .i_pair_wr_en   (pair_wr_en),
    .i_pair_sel     (pair_sel),
    .i_pair_wr_data (pair_wr_data),
    .o_rd_data      (rd_data),
    .o_acc          (acc),
    .o_hl           (hl)
  );

  alu u_alu (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_op     (alu_op),
    .i_acc    (acc),
    .i_src    (rd_data),
    .i_commit (commit),
    .o_result (alu_result)
  );

  writeback_ctrl u_writeback (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_commit       (commit),
    .i_op_class     (op_class),
    .i_dst_sel      (dst_sel),
    .i_src_data     (rd_data),
    .i_alu_result   (alu_result),
    .i_operand      (operand),
    .i_hl           (hl),
    .o_reg_wr_en    (reg_wr_en),
    .o_reg_wr_sel   (reg_wr_sel),
    .o_reg_wr_data  (reg_wr_data),
    .o_pair_wr_en   (pair_wr_en),
    .o_pair_wr_data (pair_wr_data),
    .o_mem_wr_en    (o_mem_wr_en),
    .o_mem_wr_addr  (o_mem_wr_addr),
    .o_mem_wr_data  (o_mem_wr_data)
  );

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  logic        i_clk;
  logic        i_rst;
  logic [7:0]  i_mem_rd_data;
  logic [15:0] o_mem_rd_addr;
  logic        o_mem_wr_en;
  logic [15:0] o_mem_wr_addr;
  logic [7:0]  o_mem_wr_data;

  logic [7:0]  mem [0:65535];
  logic [7:0]  ref_mem [0:65535];
  logic [7:0]  prog [$];
  logic [23:0] exp_store [$];  // Address in bits 23:8 and data in bits 7:0.
  int          exp_time [$];
  int          store_idx;
  int          clk_count;
  int          total_cycles;
  int          error_count;
  bit          limit_ready;
  logic [15:0] lfsr_state;
  string       test_name;

  cpu_top uut (.*);

  assign i_mem_rd_data = mem[o_mem_rd_addr];

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      fail_run($sformatf("[ERROR] %s: expected %0h actual %0h", name, exp, act));
    end
  endtask

  // Galois LFSR that steps once for each bit taken.
  function automatic int take_bits(input int n);
    int v;
    logic b;
    v = 0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state ^= 16'hB400;
      v = (v << 1) | b;
    end
    return v;
  endfunction

  function automatic logic [2:0] pick_dst();
    int v;
    v = take_bits(3) % 5;
    return (v == 4) ? 3'd7 : 3'(v);  // Picks B, C, D, E or A but never H or L.
  endfunction

  function automatic logic [2:0] pick_src();
    int v;
    v = take_bits(3);
    return (v == 6) ? 3'd7 : 3'(v);
  endfunction

  function automatic void push_bytes(input logic [7:0] b []);
    foreach (b[i]) prog.push_back(b[i]);
  endfunction

  function automatic void build_program(input int id);
    int kind;
    prog.delete();
    lfsr_state = 16'd23;
    case (id)
      0: push_bytes('{8'h21, 8'h00, 8'hC0, 8'h06, 8'h12, 8'h0E, 8'h34, 8'h16, 8'h56, 8'h1E, 8'h78,
                      8'h3E, 8'h9A, 8'h77, 8'h01, 8'h11, 8'h22, 8'h11, 8'h33, 8'h44, 8'h78,
                      8'h4B, 8'h70, 8'h71, 8'h72, 8'h73, 8'h77, 8'h74, 8'h75, 8'h21, 8'h10,
                      8'hC0, 8'h70, 8'h5E, 8'h73, 8'h7E, 8'h77});
      1: push_bytes('{8'h21, 8'h20, 8'hC0, 8'h3E, 8'hF0, 8'h06, 8'h20, 8'h80, 8'h77, 8'h0E,
                      8'h05, 8'h89, 8'h77, 8'h90, 8'h77, 8'h98, 8'h77, 8'hA1, 8'h77, 8'hA8,
                      8'h77, 8'hB1, 8'h77, 8'hB8, 8'h77, 8'h3E, 8'h01, 8'hB8, 8'h89, 8'h77,
                      8'h3E, 8'hF0, 8'h80, 8'h04, 8'h0D, 8'h3C, 8'h3D, 8'h89, 8'h77, 8'h70,
                      8'h71});
      2: push_bytes('{8'h21, 8'h30, 8'hC0, 8'h77, 8'h00, 8'h77, 8'h06, 8'h01, 8'h77, 8'h01,
                      8'h02, 8'h03, 8'h77, 8'h7E, 8'h77, 8'h77});
      3: push_bytes('{8'h21, 8'h40, 8'hC0, 8'h06, 8'hAB, 8'h70, 8'h31, 8'h06, 8'h55, 8'h76,
                      8'h86, 8'h08, 8'h70, 8'h77, 8'h71});
      default: begin
        push_bytes('{8'h21, 8'h00, 8'hC0});
        for (int n = 0; n < 200; n++) begin
          kind = take_bits(3);
          case (kind)
            0: push_bytes('{{2'b00, pick_dst(), 3'b110}, 8'(take_bits(8))});
            1: push_bytes('{{2'b01, pick_dst(), pick_src()}});
            2, 3: push_bytes('{{2'b10, 3'(take_bits(3)), pick_src()}});
            4: push_bytes('{{2'b00, pick_dst(), 2'b10, 1'(take_bits(1))}});
            5: begin
              if (take_bits(1)) push_bytes('{8'h21, 8'(take_bits(8)), 8'hC0});
              else push_bytes('{{3'b000, 1'(take_bits(1)), 4'h1}, 8'(take_bits(8)),
                                8'(take_bits(8))});
            end
            6: push_bytes('{{5'b01110, pick_src()}});
            default: push_bytes('{{2'b01, pick_dst(), 3'b110}});
          endcase
          if (n % 20 == 19) push_bytes('{8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77});
        end
      end
    endcase
  endfunction

  // Interprets prog and returns its total machine cycles.
  function automatic int ref_model();
    logic [7:0] r [0:7];
    logic [2:0] hi;
    logic [2:0] lo;
    logic [7:0] op;
    logic [15:0] pc;
    logic [15:0] hl;
    int cyc;
    int w;
    int c;
    exp_store.delete();
    exp_time.delete();
    foreach (r[i]) r[i] = 8'h00;
    for (int a = 0; a < 65536; a++) ref_mem[a] = 8'h00;
    foreach (prog[i]) ref_mem[16'h0100 + i] = prog[i];
    pc = 16'h0100;
    cyc = 0;
    c = 0;
    while (pc < 16'h0100 + prog.size()) begin
      op = ref_mem[pc];
      pc++;
      hi = op[5:3];
      lo = op[2:0];
      hl = {r[4], r[5]};
      cyc += 2;
      if (op[7:6] == 2'b00 && (lo == 4 || lo == 5) && hi != 6) begin
        r[hi] = (lo == 4) ? r[hi] + 8'd1 : r[hi] - 8'd1;
      end else if (op[7:6] == 2'b00 && lo == 6 && hi != 6) begin
        r[hi] = ref_mem[pc];
        pc++;
        cyc += 1;
      end else if (op[7:6] == 2'b00 && lo == 1 && !op[3] && op[5:4] != 2'b11) begin
        r[{op[5:4], 1'b1}] = ref_mem[pc];
        r[{op[5:4], 1'b0}] = ref_mem[pc + 16'd1];
        pc += 2;
        cyc += 2;
      end else if (op[7:6] == 2'b01 && !(hi == 6 && lo == 6)) begin
        if (hi == 6) begin
          ref_mem[hl] = r[lo];
          exp_store.push_back({hl, r[lo]});
          exp_time.push_back(cyc * 4);
        end else if (lo == 6) begin
          r[hi] = ref_mem[hl];
          cyc += 1;
        end else begin
          r[hi] = r[lo];
        end
      end else if (op[7:6] == 2'b10 && lo != 6) begin
        case (hi)
          0: w = r[7] + r[lo];
          1: w = r[7] + r[lo] + c;
          2, 7: w = r[7] - r[lo];
          3: w = r[7] - r[lo] - c;
          4: w = r[7] & r[lo];
          5: w = r[7] ^ r[lo];
          default: w = r[7] | r[lo];
        endcase
        c = (w > 255 || w < 0) ? 1 : 0;
        if (hi != 7) r[7] = 8'(w);
      end
    end
    return cyc;
  endfunction

  // Counts the clocks since reset for the expected store times.
  always @(posedge i_clk) begin
    if (i_rst) clk_count <= 0;
    else clk_count <= clk_count + 1;
  end

  // Compares the value and clock of each store with the next expected one.
  always @(negedge i_clk) begin
    if (!i_rst && o_mem_wr_en) begin
      if (store_idx >= exp_store.size()) begin
        fail_run($sformatf("%s: the DUT made a store that the program does not contain",
                           test_name));
      end else begin
        check($sformatf("%s store %0d", test_name, store_idx), exp_store[store_idx],
              {o_mem_wr_addr, o_mem_wr_data});
        check($sformatf("%s store %0d clock", test_name, store_idx), exp_time[store_idx],
              clk_count);
        mem[o_mem_wr_addr] = o_mem_wr_data;
        store_idx++;
      end
    end
  end

  always @(negedge i_clk) begin
    if (uut.u_sequencer.u_seq_checks.fail_count != 0 ||
        uut.u_top_checks.fail_count != 0) begin
      fail_run($sformatf("%s: a concurrent assertion on the DUT failed", test_name));
    end
  end

  initial begin
    automatic string names [5] = '{"load", "alu", "timing", "dropped", "random"};
    i_rst = 1'b1;
    store_idx = 0;
    error_count = 0;
    total_cycles = 0;
    limit_ready = 0;
    test_name = "reset";
    for (int a = 0; a < 65536; a++) mem[a] = 8'h00;
    for (int t = 0; t < 5; t++) begin
      build_program(t);
      total_cycles += ref_model() + 6;  // Reset and idle tail per program.
    end
    limit_ready = 1;
    for (int t = 0; t < 5; t++) begin
      @(negedge i_clk);
      i_rst = 1'b1;
      build_program(t);
      void'(ref_model());
      for (int a = 0; a < 65536; a++) mem[a] = 8'h00;
      foreach (prog[i]) mem[16'h0100 + i] = prog[i];
      store_idx = 0;
      test_name = names[t];
      repeat (3) @(negedge i_clk);
      check({names[t], " reset address"}, 16'h0100, o_mem_rd_addr);
      i_rst = 1'b0;
      wait (store_idx == exp_store.size());
      repeat (16) @(negedge i_clk);
    end
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit_ready);
    #(longint'(total_cycles) * 2 * 4 * 10);
    fail_run("The watchdog expired before all expected stores were seen.");
  end

endmodule

//--- verification/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_commit,
  input logic [15:0] i_rd_addr,
  input logic        i_wr_en
);

  logic [1:0] phase;  // Clock within the machine cycle, counted from reset.
  int         fail_count = 0;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  a_commit_at_t3 : assert property (@(posedge i_clk) disable iff (i_rst)
    i_commit |-> phase == 2'd3)
    else begin
      $error("commit outside T3");
      fail_count++;
    end

  a_single_store : assert property (@(posedge i_clk) disable iff (i_rst)
    i_wr_en |=> !i_wr_en)
    else begin
      $error("write strobe longer than one clock");
      fail_count++;
    end

  // The new address appears on the edge that enters T0.
  a_addr_at_t0 : assert property (@(posedge i_clk) disable iff (i_rst)
    !$stable(i_rd_addr) |-> phase == 2'd0)
    else begin
      $error("read address changed outside T0");
      fail_count++;
    end

endmodule

bind cycle_sequencer cpu_assertions u_seq_checks (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_commit  (o_commit),
  .i_rd_addr (o_mem_rd_addr),
  .i_wr_en   (1'b0)
);

bind cpu_top cpu_assertions u_top_checks (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_commit  (1'b0),
  .i_rd_addr (o_mem_rd_addr),
  .i_wr_en   (o_mem_wr_en)
);

//--- project.f
common/gb_cpu_pkg.sv
decode/instr_decoder.sv
decode/cycle_sequencer.sv
execute/reg_file.sv
execute/alu.sv
result/writeback_ctrl.sv
source/cpu_top.sv
verification/cpu_tb.sv
verification/cpu_assertions.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module cpu_tb -o sim_cpu
./obj_dir/sim_cpu 2>&1 | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
